// File: common/csr_pkg.sv
package csr_pkg;

    // datapath widths of the machine-mode register file
    localparam int csr_xlen    = 32;
    localparam int csr_cnt_w   = 64;
    localparam int csr_addr_w  = 12;
    localparam int csr_cause_w = 4;

    // machine trap setup and trap handling registers
    localparam logic [csr_addr_w-1:0] csr_addr_mstatus  = 12'h300;
    localparam logic [csr_addr_w-1:0] csr_addr_misa     = 12'h301;
    localparam logic [csr_addr_w-1:0] csr_addr_mie      = 12'h304;
    localparam logic [csr_addr_w-1:0] csr_addr_mtvec    = 12'h305;
    localparam logic [csr_addr_w-1:0] csr_addr_mscratch = 12'h340;
    localparam logic [csr_addr_w-1:0] csr_addr_mepc     = 12'h341;
    localparam logic [csr_addr_w-1:0] csr_addr_mcause   = 12'h342;
    localparam logic [csr_addr_w-1:0] csr_addr_mtval    = 12'h343;
    localparam logic [csr_addr_w-1:0] csr_addr_mip      = 12'h344;

    // machine counters, low halves at 0xb0x and high halves at 0xb8x
    localparam logic [csr_addr_w-1:0] csr_addr_mcycle    = 12'hB00;
    localparam logic [csr_addr_w-1:0] csr_addr_minstret  = 12'hB02;
    localparam logic [csr_addr_w-1:0] csr_addr_mcycleh   = 12'hB80;
    localparam logic [csr_addr_w-1:0] csr_addr_minstreth = 12'hB82;

    // user-level read-only aliases of the cycle counter
    localparam logic [csr_addr_w-1:0] csr_addr_cycle  = 12'hC00;
    localparam logic [csr_addr_w-1:0] csr_addr_cycleh = 12'hC80;

    // machine information registers, read only
    localparam logic [csr_addr_w-1:0] csr_addr_mvendorid = 12'hF11;
    localparam logic [csr_addr_w-1:0] csr_addr_marchid   = 12'hF12;
    localparam logic [csr_addr_w-1:0] csr_addr_mimpid    = 12'hF13;
    localparam logic [csr_addr_w-1:0] csr_addr_mhartid   = 12'hF14;

    // mstatus global enable, prior enable and the previous privilege field
    localparam int csr_bit_mie  = 3;
    localparam int csr_bit_mpie = 7;
    localparam int csr_mpp_lsb  = 11;

    // enable and pending positions, the same in mie and mip
    localparam int csr_bit_meie = 11;
    localparam int csr_bit_mtie = 7;
    localparam int csr_bit_msie = 3;

    // mcause interrupt flag, and the number of mepc bits held at zero
    localparam int csr_bit_irq   = 31;
    localparam int csr_epc_align = 2;

    // zero marks a non-commercial core with a single hart
    localparam logic [csr_xlen-1:0] csr_mvendorid_val = 32'h0;
    localparam logic [csr_xlen-1:0] csr_marchid_val   = 32'd22;
    localparam logic [csr_xlen-1:0] csr_mimpid_val    = 32'h0;
    localparam logic [csr_xlen-1:0] csr_mhartid_val   = 32'h0;

    // mxl of one selects rv32, extension bit 8 is I and bit 12 is M
    localparam logic [csr_xlen-1:0] csr_misa_val = {2'b01, 4'b0000, 26'h0001100};

    localparam logic [csr_xlen-1:0] csr_mtvec_reset = 32'h0;

endpackage

// File: common/csr_write_if.sv
`timescale 1ns/1ps

interface csr_write_if;

    // the write word is shared, only the strobe picks the target register
    logic [csr_pkg::csr_xlen-1:0] wdata;

    // one strobe per writable register, at most one high in a cycle
    logic wr_mstatus;
    logic wr_mie;
    logic wr_mtvec;
    logic wr_mscratch;
    logic wr_mepc;
    logic wr_mcause;
    logic wr_mtval;

    // the access control decodes, the register blocks take the word
    modport ctrl (
        output wdata, wr_mstatus, wr_mie, wr_mtvec, wr_mscratch, wr_mepc, wr_mcause, wr_mtval
    );

    modport regs (
        input wdata, wr_mstatus, wr_mie, wr_mtvec, wr_mscratch, wr_mepc, wr_mcause, wr_mtval
    );

endinterface

// File: common/csr_read_if.sv
`timescale 1ns/1ps

interface csr_read_if;

    // full-width counters, split into halves by the read multiplexer
    logic [csr_pkg::csr_cnt_w-1:0] mcycle;
    logic [csr_pkg::csr_cnt_w-1:0] minstret;

    // every word arrives already laid out as software sees it
    logic [csr_pkg::csr_xlen-1:0] mstatus;
    logic [csr_pkg::csr_xlen-1:0] mie;
    logic [csr_pkg::csr_xlen-1:0] mip;
    logic [csr_pkg::csr_xlen-1:0] mtvec;
    logic [csr_pkg::csr_xlen-1:0] mscratch;
    logic [csr_pkg::csr_xlen-1:0] mepc;
    logic [csr_pkg::csr_xlen-1:0] mcause;
    logic [csr_pkg::csr_xlen-1:0] mtval;

    // each register block drives only its own words
    modport counters (output mcycle, minstret);

    modport trap (output mstatus, mtvec, mscratch, mepc, mcause, mtval);

    modport irq (output mie, mip);

    modport ctrl (
        input mcycle, minstret, mstatus, mie, mip, mtvec, mscratch, mepc, mcause, mtval
    );

endinterface

// File: source/csr_counters.sv
`timescale 1ns/1ps

module csr_counters (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             instret_incr_i,
    csr_read_if.counters     rd_if
);

    logic [csr_pkg::csr_cnt_w-1:0] mcycle_q;
    logic [csr_pkg::csr_cnt_w-1:0] minstret_q;

    // both counters keep the full 64 bits on rv32, software reads them as halves
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mcycle_q   <= '0;
            minstret_q <= '0;
        end else begin
            // the cycle counter never stops once reset is released
            mcycle_q <= mcycle_q + 1'b1;
            // one retired instruction per cycle at most
            if (instret_incr_i) begin
                minstret_q <= minstret_q + 1'b1;
            end
        end
    end

    assign rd_if.mcycle   = mcycle_q;
    assign rd_if.minstret = minstret_q;

endmodule

// File: source/csr_trap_regs.sv
`timescale 1ns/1ps

module csr_trap_regs (
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  logic                              set_cause_i,
    input  logic                              trap_is_irq_i,
    input  logic [csr_pkg::csr_cause_w-1:0]   trap_cause_i,
    input  logic                              set_epc_i,
    input  logic [csr_pkg::csr_xlen-1:0]      epc_i,
    input  logic                              set_mtval_i,
    input  logic [csr_pkg::csr_xlen-1:0]      mtval_i,
    input  logic                              mstatus_ie_clear_i,
    input  logic                              mstatus_ie_set_i,
    output logic                              mstatus_ie_o,
    output logic [csr_pkg::csr_xlen-1:0]      mtvec_o,
    output logic [csr_pkg::csr_xlen-1:0]      epc_o,
    csr_write_if.regs                         wr_if,
    csr_read_if.trap                          rd_if
);

    logic                         mstatus_ie_q;
    logic                         mstatus_pie_q;
    logic [csr_pkg::csr_xlen-1:0] mtvec_q;
    logic [csr_pkg::csr_xlen-1:0] mscratch_q;
    logic [csr_pkg::csr_xlen-1:0] mepc_q;
    logic [csr_pkg::csr_xlen-1:0] mepc_next;
    logic [csr_pkg::csr_xlen-1:0] mcause_q;
    logic [csr_pkg::csr_xlen-1:0] mcause_trap;
    logic [csr_pkg::csr_xlen-1:0] mtval_q;

    // software write first, then trap entry, then trap return
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mstatus_ie_q  <= 1'b0;
            mstatus_pie_q <= 1'b1;
        end else if (wr_if.wr_mstatus) begin
            mstatus_ie_q  <= wr_if.wdata[csr_pkg::csr_bit_mie];
            mstatus_pie_q <= wr_if.wdata[csr_pkg::csr_bit_mpie];
        end else if (mstatus_ie_clear_i) begin
            // trap entry saves the enable and masks further interrupts
            mstatus_pie_q <= mstatus_ie_q;
            mstatus_ie_q  <= 1'b0;
        end else if (mstatus_ie_set_i) begin
            // mret brings the saved enable back
            mstatus_ie_q  <= mstatus_pie_q;
            mstatus_pie_q <= 1'b1;
        end
    end

    // only direct mode is supported, so mtvec is kept exactly as written
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mtvec_q <= csr_pkg::csr_mtvec_reset;
        end else if (wr_if.wr_mtvec) begin
            mtvec_q <= wr_if.wdata;
        end
    end

    // the trap address wins over a software write, and ialign is 32 either way
    always_comb begin
        mepc_next = set_epc_i ? epc_i : wr_if.wdata;
        mepc_next[csr_pkg::csr_epc_align-1:0] = '0;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mepc_q <= '0;
        end else if (set_epc_i || wr_if.wr_mepc) begin
            mepc_q <= mepc_next;
        end
    end

    // a hardware cause has only the interrupt flag and the code, the rest reads zero
    always_comb begin
        mcause_trap = '0;
        mcause_trap[csr_pkg::csr_bit_irq] = trap_is_irq_i;
        mcause_trap[csr_pkg::csr_cause_w-1:0] = trap_cause_i;
    end

    // the scratch, cause and value words carry whatever the handler or the trap put there
    always_ff @(posedge clk_i) begin
        if (wr_if.wr_mscratch) begin
            mscratch_q <= wr_if.wdata;
        end
        if (set_cause_i) begin
            mcause_q <= mcause_trap;
        end else if (wr_if.wr_mcause) begin
            mcause_q <= wr_if.wdata;
        end
        if (set_mtval_i) begin
            mtval_q <= mtval_i;
        end else if (wr_if.wr_mtval) begin
            mtval_q <= wr_if.wdata;
        end
    end

    // mpp is hardwired to machine mode since no lower privilege exists
    always_comb begin
        rd_if.mstatus = '0;
        rd_if.mstatus[csr_pkg::csr_bit_mie] = mstatus_ie_q;
        rd_if.mstatus[csr_pkg::csr_bit_mpie] = mstatus_pie_q;
        rd_if.mstatus[csr_pkg::csr_mpp_lsb +: 2] = 2'b11;
    end

    assign rd_if.mtvec    = mtvec_q;
    assign rd_if.mscratch = mscratch_q;
    assign rd_if.mepc     = mepc_q;
    assign rd_if.mcause   = mcause_q;
    assign rd_if.mtval    = mtval_q;

    assign mstatus_ie_o = mstatus_ie_q;
    assign mtvec_o      = mtvec_q;
    assign epc_o        = mepc_q;

    // the core never enters and returns from a trap in the same cycle
    assert property (@(posedge clk_i) disable iff (rst_i)
        !(mstatus_ie_clear_i && mstatus_ie_set_i))
        else $error("mstatus enable clear and set requested together");

    // the return address stays aligned through reset, traps and software writes
    assert property (@(posedge clk_i) disable iff (rst_i)
        mepc_q[csr_pkg::csr_epc_align-1:0] == '0)
        else $error("mepc holds a misaligned return address");

endmodule

// File: source/csr_irq_regs.sv
`timescale 1ns/1ps

module csr_irq_regs (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        irq_software_i,
    input  logic        irq_timer_i,
    input  logic        irq_external_i,
    output logic        mie_external_o,
    output logic        mie_timer_o,
    output logic        mie_sw_o,
    output logic        mip_external_o,
    output logic        mip_timer_o,
    output logic        mip_sw_o,
    csr_write_if.regs   wr_if,
    csr_read_if.irq     rd_if
);

    logic mie_external_q;
    logic mie_timer_q;
    logic mie_sw_q;
    logic mip_external_q;
    logic mip_timer_q;
    logic mip_sw_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mie_external_q <= 1'b0;
            mie_timer_q    <= 1'b0;
            mie_sw_q       <= 1'b0;
            mip_external_q <= 1'b0;
            mip_timer_q    <= 1'b0;
            mip_sw_q       <= 1'b0;
        end else begin
            // pending bits are not writable, they follow the lines one cycle late
            mip_external_q <= irq_external_i;
            mip_timer_q    <= irq_timer_i;
            mip_sw_q       <= irq_software_i;
            // supervisor and user enables are not implemented and are dropped
            if (wr_if.wr_mie) begin
                mie_external_q <= wr_if.wdata[csr_pkg::csr_bit_meie];
                mie_timer_q    <= wr_if.wdata[csr_pkg::csr_bit_mtie];
                mie_sw_q       <= wr_if.wdata[csr_pkg::csr_bit_msie];
            end
        end
    end

    // both words use the same bit positions, everything else reads zero
    always_comb begin
        rd_if.mie = '0;
        rd_if.mie[csr_pkg::csr_bit_meie] = mie_external_q;
        rd_if.mie[csr_pkg::csr_bit_mtie] = mie_timer_q;
        rd_if.mie[csr_pkg::csr_bit_msie] = mie_sw_q;
        rd_if.mip = '0;
        rd_if.mip[csr_pkg::csr_bit_meie] = mip_external_q;
        rd_if.mip[csr_pkg::csr_bit_mtie] = mip_timer_q;
        rd_if.mip[csr_pkg::csr_bit_msie] = mip_sw_q;
    end

    assign mie_external_o = mie_external_q;
    assign mie_timer_o    = mie_timer_q;
    assign mie_sw_o       = mie_sw_q;
    assign mip_external_o = mip_external_q;
    assign mip_timer_o    = mip_timer_q;
    assign mip_sw_o       = mip_sw_q;

endmodule

// File: source/csr_access_ctrl.sv
`timescale 1ns/1ps

module csr_access_ctrl (
    input  logic                              we_i,
    input  logic [csr_pkg::csr_addr_w-1:0]    waddr_i,
    input  logic [csr_pkg::csr_xlen-1:0]      wdata_i,
    input  logic [csr_pkg::csr_addr_w-1:0]    raddr_i,
    output logic [csr_pkg::csr_xlen-1:0]      rdata_o,
    csr_write_if.ctrl                         wr_if,
    csr_read_if.ctrl                          rd_if
);

    logic [csr_pkg::csr_xlen-1:0] rd_word;

    // every register sees the same write word, the strobe alone selects it
    assign wr_if.wdata = wdata_i;

    // writes to read-only or unknown addresses raise no strobe and are lost
    assign wr_if.wr_mstatus  = we_i && (waddr_i == csr_pkg::csr_addr_mstatus);
    assign wr_if.wr_mie      = we_i && (waddr_i == csr_pkg::csr_addr_mie);
    assign wr_if.wr_mtvec    = we_i && (waddr_i == csr_pkg::csr_addr_mtvec);
    assign wr_if.wr_mscratch = we_i && (waddr_i == csr_pkg::csr_addr_mscratch);
    assign wr_if.wr_mepc     = we_i && (waddr_i == csr_pkg::csr_addr_mepc);
    assign wr_if.wr_mcause   = we_i && (waddr_i == csr_pkg::csr_addr_mcause);
    assign wr_if.wr_mtval    = we_i && (waddr_i == csr_pkg::csr_addr_mtval);

    // read multiplexer over the register words and the fixed identity values
    always_comb begin
        case (raddr_i)
            csr_pkg::csr_addr_mvendorid: rd_word = csr_pkg::csr_mvendorid_val;
            csr_pkg::csr_addr_marchid:   rd_word = csr_pkg::csr_marchid_val;
            csr_pkg::csr_addr_mimpid:    rd_word = csr_pkg::csr_mimpid_val;
            csr_pkg::csr_addr_mhartid:   rd_word = csr_pkg::csr_mhartid_val;
            csr_pkg::csr_addr_misa:      rd_word = csr_pkg::csr_misa_val;
            // the user cycle aliases share the machine cycle counter
            csr_pkg::csr_addr_mcycle,
            csr_pkg::csr_addr_cycle: begin
                rd_word = rd_if.mcycle[csr_pkg::csr_xlen-1:0];
            end
            csr_pkg::csr_addr_mcycleh,
            csr_pkg::csr_addr_cycleh: begin
                rd_word = rd_if.mcycle[csr_pkg::csr_cnt_w-1:csr_pkg::csr_xlen];
            end
            csr_pkg::csr_addr_minstret: begin
                rd_word = rd_if.minstret[csr_pkg::csr_xlen-1:0];
            end
            csr_pkg::csr_addr_minstreth: begin
                rd_word = rd_if.minstret[csr_pkg::csr_cnt_w-1:csr_pkg::csr_xlen];
            end
            csr_pkg::csr_addr_mstatus:  rd_word = rd_if.mstatus;
            csr_pkg::csr_addr_mie:      rd_word = rd_if.mie;
            csr_pkg::csr_addr_mip:      rd_word = rd_if.mip;
            csr_pkg::csr_addr_mtvec:    rd_word = rd_if.mtvec;
            csr_pkg::csr_addr_mscratch: rd_word = rd_if.mscratch;
            csr_pkg::csr_addr_mepc:     rd_word = rd_if.mepc;
            csr_pkg::csr_addr_mcause:   rd_word = rd_if.mcause;
            csr_pkg::csr_addr_mtval:    rd_word = rd_if.mtval;
            default:                    rd_word = '0;
        endcase
    end

    // a write to the address being read shows its data in the same cycle
    // this holds for any address, the read-only words included
    assign rdata_o = (we_i && (waddr_i == raddr_i)) ? wdata_i : rd_word;

    // the register blocks rely on a single strobe per write for their priorities
    always_comb begin
        assert ($onehot0({wr_if.wr_mstatus, wr_if.wr_mie, wr_if.wr_mtvec, wr_if.wr_mscratch,
                          wr_if.wr_mepc, wr_if.wr_mcause, wr_if.wr_mtval}))
            else $error("more than one csr write strobe is active");
    end

endmodule

// File: source/csr_file.sv
`timescale 1ns/1ps

module csr_file (
    input  logic                              clk_i,
    input  logic                              rst_i,

    // interrupt lines from the timer and interrupt controllers
    input  logic                              irq_software_i,
    input  logic                              irq_timer_i,
    input  logic                              irq_external_i,

    // combinational read port
    input  logic [csr_pkg::csr_addr_w-1:0]    raddr_i,
    output logic [csr_pkg::csr_xlen-1:0]      rdata_o,

    // single-cycle write port
    input  logic                              we_i,
    input  logic [csr_pkg::csr_addr_w-1:0]    waddr_i,
    input  logic [csr_pkg::csr_xlen-1:0]      wdata_i,

    // trap-side updates from the core
    input  logic                              instret_incr_i,
    input  logic                              set_cause_i,
    input  logic                              trap_is_irq_i,
    input  logic [csr_pkg::csr_cause_w-1:0]   trap_cause_i,
    input  logic                              set_epc_i,
    input  logic [csr_pkg::csr_xlen-1:0]      epc_i,
    input  logic                              set_mtval_i,
    input  logic [csr_pkg::csr_xlen-1:0]      mtval_i,
    input  logic                              mstatus_ie_clear_i,
    input  logic                              mstatus_ie_set_i,

    // state the core needs to take and return from traps
    output logic                              mstatus_ie_o,
    output logic                              mie_external_o,
    output logic                              mie_timer_o,
    output logic                              mie_sw_o,
    output logic                              mip_external_o,
    output logic                              mip_timer_o,
    output logic                              mip_sw_o,
    output logic [csr_pkg::csr_xlen-1:0]      mtvec_o,
    output logic [csr_pkg::csr_xlen-1:0]      epc_o
);

    // decoded strobes fan out to the registers, their words come back for reads
    csr_write_if u_wr_if ();
    csr_read_if  u_rd_if ();

    csr_access_ctrl u_access_ctrl (
        .we_i    (we_i),
        .waddr_i (waddr_i),
        .wdata_i (wdata_i),
        .raddr_i (raddr_i),
        .rdata_o (rdata_o),
        .wr_if   (u_wr_if),
        .rd_if   (u_rd_if)
    );

    csr_counters u_counters (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .instret_incr_i (instret_incr_i),
        .rd_if          (u_rd_if)
    );

    csr_trap_regs u_trap_regs (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .set_cause_i        (set_cause_i),
        .trap_is_irq_i      (trap_is_irq_i),
        .trap_cause_i       (trap_cause_i),
        .set_epc_i          (set_epc_i),
        .epc_i              (epc_i),
        .set_mtval_i        (set_mtval_i),
        .mtval_i            (mtval_i),
        .mstatus_ie_clear_i (mstatus_ie_clear_i),
        .mstatus_ie_set_i   (mstatus_ie_set_i),
        .mstatus_ie_o       (mstatus_ie_o),
        .mtvec_o            (mtvec_o),
        .epc_o              (epc_o),
        .wr_if              (u_wr_if),
        .rd_if              (u_rd_if)
    );

    csr_irq_regs u_irq_regs (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .irq_software_i (irq_software_i),
        .irq_timer_i    (irq_timer_i),
        .irq_external_i (irq_external_i),
        .mie_external_o (mie_external_o),
        .mie_timer_o    (mie_timer_o),
        .mie_sw_o       (mie_sw_o),
        .mip_external_o (mip_external_o),
        .mip_timer_o    (mip_timer_o),
        .mip_sw_o       (mip_sw_o),
        .wr_if          (u_wr_if),
        .rd_if          (u_rd_if)
    );

endmodule

// File: bench/csr_file_tb.sv
`timescale 1ns/1ps

module csr_file_tb;

    // the pending bits must show up within this many cycles
    localparam int mip_timeout = 8;

    logic        clk_i;
    logic        rst_i;
    logic        irq_software_i;
    logic        irq_timer_i;
    logic        irq_external_i;
    logic [11:0] raddr_i;
    logic [31:0] rdata_o;
    logic        we_i;
    logic [11:0] waddr_i;
    logic [31:0] wdata_i;
    logic        instret_incr_i;
    logic        set_cause_i;
    logic        trap_is_irq_i;
    logic [3:0]  trap_cause_i;
    logic        set_epc_i;
    logic [31:0] epc_i;
    logic        set_mtval_i;
    logic [31:0] mtval_i;
    logic        mstatus_ie_clear_i;
    logic        mstatus_ie_set_i;
    logic        mstatus_ie_o;
    logic        mie_external_o;
    logic        mie_timer_o;
    logic        mie_sw_o;
    logic        mip_external_o;
    logic        mip_timer_o;
    logic        mip_sw_o;
    logic [31:0] mtvec_o;
    logic [31:0] epc_o;
    logic [15:0] lfsr_state;

    csr_file u_dut (.*);

    always #20 clk_i = ~clk_i;

    // 16-bit fibonacci lfsr with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // each lfsr step yields one bit and the newest bit ends up in the lsb
    task automatic random_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    // builds the architectural mstatus layout where mpp is always machine mode
    function automatic logic [31:0] mstatus_word(input logic ie, input logic pie);
        logic [31:0] word;
        word = '0;
        word[csr_pkg::csr_bit_mie] = ie;
        word[csr_pkg::csr_bit_mpie] = pie;
        word[csr_pkg::csr_mpp_lsb +: 2] = 2'b11;
        return word;
    endfunction

    // three-bit enable or pending pattern placed at the mie and mip positions
    function automatic logic [31:0] irq_word(input logic [2:0] pattern);
        logic [31:0] word;
        word = '0;
        word[csr_pkg::csr_bit_meie] = pattern[2];
        word[csr_pkg::csr_bit_mtie] = pattern[1];
        word[csr_pkg::csr_bit_msie] = pattern[0];
        return word;
    endfunction

    // the read port is combinational, so the word is taken mid-cycle
    task automatic read_csr(input logic [11:0] addr, output logic [31:0] value);
        @(posedge clk_i);
        raddr_i <= addr;
        @(negedge clk_i);
        value = rdata_o;
    endtask

    task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
        @(posedge clk_i);
        we_i    <= 1'b1;
        waddr_i <= addr;
        wdata_i <= data;
        @(posedge clk_i);
        we_i    <= 1'b0;
    endtask

    task automatic reset_and_identity();
        logic [31:0] value;
        @(negedge clk_i);
        check("reset mie outputs", 32'h0, {mie_external_o, mie_timer_o, mie_sw_o});
        check("reset mip outputs", 32'h0, {mip_external_o, mip_timer_o, mip_sw_o});
        check("reset mstatus_ie_o", 32'h0, mstatus_ie_o);
        check("reset mtvec_o", 32'h0, mtvec_o);
        check("reset epc_o", 32'h0, epc_o);
        read_csr(csr_pkg::csr_addr_mstatus, value);
        check("reset mstatus", mstatus_word(1'b0, 1'b1), value);
        read_csr(csr_pkg::csr_addr_mvendorid, value);
        check("mvendorid", 32'h0, value);
        read_csr(csr_pkg::csr_addr_marchid, value);
        check("marchid", 32'd22, value);
        read_csr(csr_pkg::csr_addr_mimpid, value);
        check("mimpid", 32'h0, value);
        read_csr(csr_pkg::csr_addr_mhartid, value);
        check("mhartid", 32'h0, value);
        // mxl of one in the top two bits, the I extension at bit 8 and M at bit 12
        read_csr(csr_pkg::csr_addr_misa, value);
        check("misa", 32'h4000_1100, value);
        // 0x7c0 is a custom address that this file leaves unimplemented
        read_csr(12'h7C0, value);
        check("unused address", 32'h0, value);
    endtask

    task automatic write_readback();
        logic [31:0] data;
        logic [31:0] value;
        // mtvec_o keeps the old target until the write edge has passed
        random_bits(32, data);
        @(posedge clk_i);
        we_i    <= 1'b1;
        waddr_i <= csr_pkg::csr_addr_mtvec;
        wdata_i <= data;
        @(negedge clk_i);
        check("mtvec_o before write", 32'h0, mtvec_o);
        @(posedge clk_i);
        we_i <= 1'b0;
        @(negedge clk_i);
        check("mtvec_o after write", data, mtvec_o);
        read_csr(csr_pkg::csr_addr_mtvec, value);
        check("mtvec readback", data, value);
        // the return address follows the same timing with the low bits dropped
        random_bits(32, data);
        @(posedge clk_i);
        we_i    <= 1'b1;
        waddr_i <= csr_pkg::csr_addr_mepc;
        wdata_i <= data;
        @(negedge clk_i);
        check("epc_o before write", 32'h0, epc_o);
        @(posedge clk_i);
        we_i <= 1'b0;
        @(negedge clk_i);
        check("epc_o after write", data & 32'hFFFF_FFFC, epc_o);
        read_csr(csr_pkg::csr_addr_mepc, value);
        check("mepc readback", data & 32'hFFFF_FFFC, value);
        random_bits(32, data);
        write_csr(csr_pkg::csr_addr_mscratch, data);
        read_csr(csr_pkg::csr_addr_mscratch, value);
        check("mscratch readback", data, value);
        random_bits(32, data);
        write_csr(csr_pkg::csr_addr_mcause, data);
        read_csr(csr_pkg::csr_addr_mcause, value);
        check("mcause readback", data, value);
        random_bits(32, data);
        write_csr(csr_pkg::csr_addr_mtval, data);
        read_csr(csr_pkg::csr_addr_mtval, value);
        check("mtval readback", data, value);
        // only the three machine enables survive a write to mie
        random_bits(32, data);
        write_csr(csr_pkg::csr_addr_mie, data);
        read_csr(csr_pkg::csr_addr_mie, value);
        check("mie readback", irq_word({data[11], data[7], data[3]}), value);
        check("mie outputs", {data[11], data[7], data[3]},
              {mie_external_o, mie_timer_o, mie_sw_o});
    endtask

    task automatic write_forwarding();
        logic [31:0] data;
        random_bits(32, data);
        @(posedge clk_i);
        we_i    <= 1'b1;
        waddr_i <= csr_pkg::csr_addr_mscratch;
        raddr_i <= csr_pkg::csr_addr_mscratch;
        wdata_i <= data;
        @(negedge clk_i);
        check("forward mscratch", data, rdata_o);
        // a read-only word is forwarded too, although the write itself is lost
        random_bits(32, data);
        @(posedge clk_i);
        waddr_i <= csr_pkg::csr_addr_mvendorid;
        raddr_i <= csr_pkg::csr_addr_mvendorid;
        wdata_i <= data;
        @(negedge clk_i);
        check("forward mvendorid", data, rdata_o);
        @(posedge clk_i);
        we_i <= 1'b0;
        @(negedge clk_i);
        check("mvendorid after write", 32'h0, rdata_o);
    endtask

    task automatic trap_entry_return();
        logic [31:0] epc;
        logic [31:0] tval;
        logic [31:0] cause;
        logic [31:0] soft_cause;
        logic [31:0] exp_cause;
        logic [31:0] value;
        write_csr(csr_pkg::csr_addr_mstatus, mstatus_word(1'b1, 1'b0));
        @(negedge clk_i);
        check("mstatus_ie_o enabled", 32'h1, mstatus_ie_o);
        random_bits(32, epc);
        random_bits(32, tval);
        random_bits(4, cause);
        // trap entry raises every trap-side strobe for a single cycle
        @(posedge clk_i);
        mstatus_ie_clear_i <= 1'b1;
        set_epc_i          <= 1'b1;
        epc_i              <= epc;
        set_cause_i        <= 1'b1;
        trap_is_irq_i      <= 1'b1;
        trap_cause_i       <= cause[3:0];
        set_mtval_i        <= 1'b1;
        mtval_i            <= tval;
        @(posedge clk_i);
        mstatus_ie_clear_i <= 1'b0;
        set_epc_i          <= 1'b0;
        set_cause_i        <= 1'b0;
        set_mtval_i        <= 1'b0;
        exp_cause = '0;
        exp_cause[csr_pkg::csr_bit_irq] = 1'b1;
        exp_cause[3:0] = cause[3:0];
        read_csr(csr_pkg::csr_addr_mepc, value);
        check("trap mepc", epc & 32'hFFFF_FFFC, value);
        read_csr(csr_pkg::csr_addr_mcause, value);
        check("trap mcause", exp_cause, value);
        read_csr(csr_pkg::csr_addr_mtval, value);
        check("trap mtval", tval, value);
        read_csr(csr_pkg::csr_addr_mstatus, value);
        check("trap mstatus", mstatus_word(1'b0, 1'b1), value);
        check("trap mstatus_ie_o", 32'h0, mstatus_ie_o);
        // trap return brings the saved enable back
        @(posedge clk_i);
        mstatus_ie_set_i <= 1'b1;
        @(posedge clk_i);
        mstatus_ie_set_i <= 1'b0;
        read_csr(csr_pkg::csr_addr_mstatus, value);
        check("return mstatus", mstatus_word(1'b1, 1'b1), value);
        check("return mstatus_ie_o", 32'h1, mstatus_ie_o);
        // the hardware cause beats a software write in the same cycle
        random_bits(4, cause);
        random_bits(32, soft_cause);
        @(posedge clk_i);
        set_cause_i   <= 1'b1;
        trap_is_irq_i <= 1'b0;
        trap_cause_i  <= cause[3:0];
        we_i          <= 1'b1;
        waddr_i       <= csr_pkg::csr_addr_mcause;
        wdata_i       <= soft_cause;
        @(posedge clk_i);
        set_cause_i <= 1'b0;
        we_i        <= 1'b0;
        read_csr(csr_pkg::csr_addr_mcause, value);
        check("mcause priority", {28'h0, cause[3:0]}, value);
    endtask

    task automatic counter_steps();
        logic [31:0] gap;
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] pulse;
        int          count;
        random_bits(4, gap);
        gap = gap + 3;
        read_csr(csr_pkg::csr_addr_mcycle, first);
        repeat (gap) @(negedge clk_i);
        second = rdata_o;
        check("mcycle distance", gap, second - first);
        read_csr(csr_pkg::csr_addr_cycle, first);
        repeat (gap) @(negedge clk_i);
        second = rdata_o;
        check("cycle distance", gap, second - first);
        // the retire pattern takes one lfsr bit per cycle
        count = 0;
        read_csr(csr_pkg::csr_addr_minstret, first);
        for (int i = 0; i < 24; i++) begin
            random_bits(1, pulse);
            @(posedge clk_i);
            instret_incr_i <= pulse[0];
            if (pulse[0]) begin
                count++;
            end
        end
        @(posedge clk_i);
        instret_incr_i <= 1'b0;
        read_csr(csr_pkg::csr_addr_minstret, second);
        check("minstret pulses", count, second - first);
    endtask

    // counts the negedges until the mip outputs show the pattern
    task automatic wait_for_mip(input logic [2:0] pattern, output int cycles);
        cycles = 0;
        @(negedge clk_i);
        while ({mip_external_o, mip_timer_o, mip_sw_o} !== pattern) begin
            if (cycles == mip_timeout) begin
                $display("timeout, the mip outputs never followed the interrupt lines");
                abort_run();
            end else begin
                @(negedge clk_i);
                cycles++;
            end
        end
    endtask

    task automatic irq_pending();
        logic [2:0] pattern;
        int         cycles;
        // patterns 1 to 7 and then 0, so each one differs from the one before
        for (int p = 1; p <= 8; p++) begin
            pattern = p[2:0];
            @(posedge clk_i);
            irq_external_i <= pattern[2];
            irq_timer_i    <= pattern[1];
            irq_software_i <= pattern[0];
            raddr_i        <= csr_pkg::csr_addr_mip;
            wait_for_mip(pattern, cycles);
            check("mip latency", 32'd1, cycles);
            check("mip word", irq_word(pattern), rdata_o);
        end
    endtask

    initial begin
        clk_i              = 1'b0;
        rst_i              = 1'b1;
        irq_software_i     = 1'b0;
        irq_timer_i        = 1'b0;
        irq_external_i     = 1'b0;
        raddr_i            = '0;
        we_i               = 1'b0;
        waddr_i            = '0;
        wdata_i            = '0;
        instret_incr_i     = 1'b0;
        set_cause_i        = 1'b0;
        trap_is_irq_i      = 1'b0;
        trap_cause_i       = '0;
        set_epc_i          = 1'b0;
        epc_i              = '0;
        set_mtval_i        = 1'b0;
        mtval_i            = '0;
        mstatus_ie_clear_i = 1'b0;
        mstatus_ie_set_i   = 1'b0;
        lfsr_state         = 16'd5;
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b0;
        reset_and_identity();
        write_readback();
        write_forwarding();
        trap_entry_return();
        counter_steps();
        irq_pending();
        $display("Everything OK");
        $finish;
    end

endmodule

// File: list.f
common/csr_pkg.sv
common/csr_write_if.sv
common/csr_read_if.sv
source/csr_counters.sv
source/csr_trap_regs.sv
source/csr_irq_regs.sv
source/csr_access_ctrl.sv
source/csr_file.sv
bench/csr_file_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= csr_file_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
